// File: Makefile
# Verilator build and run of the scalar decode stage

VERILATOR ?= verilator
TOP       ?= any1_decode_tb
SEED      ?= 74
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

FILELIST := project.f
SRCS     := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS     := $(wildcard include/*.svh)
BIN      := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/any1_decode_buffer.sv
/* Decode output buffer and issue sender */

`timescale 1ns/1ns

module any1_decode_buffer import any1_isa_pkg::*, any1_uop_pkg::*; #(
	parameter int INSN_W = INSN_WIDTH,
	parameter int XLEN = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              slot_full,
	input  logic [INSN_W-1:0] slot_ir,
	input  logic [XLEN-1:0]   slot_ip,
	output logic              slot_take,
	input  logic              ui,
	input  logic              rfwr,
	input  logic              need_rb,
	input  logic              need_rc,
	input  logic              rc_en,
	input  logic              mc,
	input  logic              branch,
	input  logic              mem_op,
	input  rt_sel_e           rt_sel,
	input  logic [XLEN-1:0]   imm,
	input  logic              out_ack,
	output logic              out_req,
	output logic [XLEN-1:0]   out_ip,
	output logic [REG_W-1:0]  out_ra,
	output logic [REG_W-1:0]  out_rb,
	output logic [REG_W-1:0]  out_rc,
	output logic [REG_W-1:0]  out_rt,
	output logic              out_rfwr,
	output logic              out_need_rb,
	output logic              out_need_rc,
	output logic              out_mc,
	output logic              out_branch,
	output logic              out_mem_op,
	output logic              out_ui,
	output logic [XLEN-1:0]   out_imm
);

	typedef enum logic [1:0] {EMPTY, OFFER, RELEASE} tx_state_e;

	tx_state_e        state;
	logic [REG_W-1:0] rt_next;
	logic [REG_W-1:0] rc_next;

	assign slot_take = (state == EMPTY) && slot_full;
	assign out_req = (state == OFFER);

	// JAL links through one of four registers named by bits 9..8
	always_comb begin
		case (rt_sel)
		RT_FIELD: rt_next = slot_ir[RT_HI:RT_LO];
		RT_LINK:  rt_next = {{(REG_W-2){1'b0}}, slot_ir[9:8]};
		default:  rt_next = '0;
		endcase
	end

	// CHK reads its third operand from the Rt field position
	assign rc_next = rc_en ? slot_ir[RT_HI:RT_LO] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= EMPTY;
		else begin
			case (state)
			EMPTY:
				if (slot_full)
					state <= OFFER;
			OFFER:
				if (out_ack)
					state <= RELEASE;
			RELEASE:
				if (!out_ack)
					state <= EMPTY;
			default:
				state <= EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (slot_take) begin
			out_ip <= slot_ip;
			out_ra <= slot_ir[RA_HI:RA_LO];
			out_rb <= slot_ir[RB_HI:RB_LO];
			out_rc <= rc_next;
			out_rt <= rt_next;
			out_rfwr <= rfwr;
			out_need_rb <= need_rb;
			out_need_rc <= need_rc;
			out_mc <= mc;
			out_branch <= branch;
			out_mem_op <= mem_op;
			out_ui <= ui;
			out_imm <= imm;
		end
	end

endmodule

// File: hdl/any1_decode_top.sv
/* Scalar decode stage */

`timescale 1ns/1ns

module any1_decode_top import any1_isa_pkg::*, any1_uop_pkg::*; #(
	parameter int INSN_W = INSN_WIDTH,
	parameter int XLEN = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_req,
	input  logic [INSN_W-1:0] in_ir,
	input  logic [XLEN-1:0]   in_ip,
	output logic              in_ack,
	input  logic              out_ack,
	output logic              out_req,
	output logic [XLEN-1:0]   out_ip,
	output logic [REG_W-1:0]  out_ra,
	output logic [REG_W-1:0]  out_rb,
	output logic [REG_W-1:0]  out_rc,
	output logic [REG_W-1:0]  out_rt,
	output logic              out_rfwr,
	output logic              out_need_rb,
	output logic              out_need_rc,
	output logic              out_mc,
	output logic              out_branch,
	output logic              out_mem_op,
	output logic              out_ui,
	output logic [XLEN-1:0]   out_imm
);

	// Input slot
	logic              slot_full;
	logic              slot_take;
	logic [INSN_W-1:0] slot_ir;
	logic [XLEN-1:0]   slot_ip;

	// Combinational decode of the slot
	logic      ui;
	logic      rfwr;
	logic      need_rb;
	logic      need_rc;
	logic      rc_en;
	logic      mc;
	logic      branch;
	logic      mem_op;
	imm_kind_e imm_kind;
	rt_sel_e   rt_sel;
	logic [XLEN-1:0] imm;

	any1_fetch_port #(.INSN_W(INSN_W), .XLEN(XLEN)) fetch0 (
		.clk(clk), .rst_n(rst_n),
		.in_req(in_req), .in_ir(in_ir), .in_ip(in_ip), .in_ack(in_ack),
		.slot_take(slot_take), .slot_full(slot_full),
		.slot_ir(slot_ir), .slot_ip(slot_ip)
	);

	any1_opcode_classify #(.INSN_W(INSN_W), .XLEN(XLEN)) classify0 (
		.slot_ir(slot_ir),
		.ui(ui), .rfwr(rfwr), .need_rb(need_rb), .need_rc(need_rc),
		.rc_en(rc_en), .mc(mc), .branch(branch), .mem_op(mem_op),
		.imm_kind(imm_kind), .rt_sel(rt_sel)
	);

	any1_imm_gen #(.INSN_W(INSN_W), .XLEN(XLEN)) immgen0 (
		.slot_ir(slot_ir), .imm_kind(imm_kind), .imm(imm)
	);

	any1_decode_buffer #(.INSN_W(INSN_W), .XLEN(XLEN)) buffer0 (
		.clk(clk), .rst_n(rst_n),
		.slot_full(slot_full), .slot_ir(slot_ir), .slot_ip(slot_ip),
		.slot_take(slot_take),
		.ui(ui), .rfwr(rfwr), .need_rb(need_rb), .need_rc(need_rc),
		.rc_en(rc_en), .mc(mc), .branch(branch), .mem_op(mem_op),
		.rt_sel(rt_sel), .imm(imm),
		.out_ack(out_ack), .out_req(out_req), .out_ip(out_ip),
		.out_ra(out_ra), .out_rb(out_rb), .out_rc(out_rc), .out_rt(out_rt),
		.out_rfwr(out_rfwr), .out_need_rb(out_need_rb), .out_need_rc(out_need_rc),
		.out_mc(out_mc), .out_branch(out_branch), .out_mem_op(out_mem_op),
		.out_ui(out_ui), .out_imm(out_imm)
	);

endmodule

// File: hdl/any1_fetch_port.sv
/* Fetch receiver and input slot */

`timescale 1ns/1ns

module any1_fetch_port import any1_isa_pkg::*; #(
	parameter int INSN_W = INSN_WIDTH,
	parameter int XLEN = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_req,
	input  logic [INSN_W-1:0] in_ir,
	input  logic [XLEN-1:0]   in_ip,
	output logic              in_ack,
	input  logic              slot_take,
	output logic              slot_full,
	output logic [INSN_W-1:0] slot_ir,
	output logic [XLEN-1:0]   slot_ip
);

	typedef enum logic {IDLE, ACKED} rx_state_e;

	rx_state_e state;
	logic      capture;

	// A request is only taken while the slot has room
	assign capture = (state == IDLE) && in_req && !slot_full;
	assign in_ack = (state == ACKED);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			slot_full <= 1'b0;
		end else begin
			case (state)
			IDLE:
				if (capture)
					state <= ACKED;
			ACKED:
				if (!in_req)
					state <= IDLE;
			default:
				state <= IDLE;
			endcase
			// Capture and take never coincide since one needs an empty slot
			if (capture)
				slot_full <= 1'b1;
			else if (slot_take)
				slot_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			slot_ir <= in_ir;
			slot_ip <= in_ip;
		end
	end

endmodule

// File: hdl/any1_imm_gen.sv
/* Immediate generation */

`timescale 1ns/1ns

module any1_imm_gen import any1_isa_pkg::*, any1_uop_pkg::*; #(
	parameter int INSN_W = INSN_WIDTH,
	parameter int XLEN = 64
) (
	input  logic [INSN_W-1:0] slot_ir,
	input  imm_kind_e         imm_kind,
	output logic [XLEN-1:0]   imm
);

	localparam int IMM14_W = IMM14_HI - IMM14_LO + 1;

	logic [IMM14_W-1:0] imm14;
	logic [REG_W-1:0]   shamt;
	logic [11:0]        bdisp;
	logic [25:0]        jdisp;
	logic [9:0]         ldisp;
	logic [9:0]         sdisp;

	// Raw fields before extension
	assign imm14 = slot_ir[IMM14_HI:IMM14_LO];
	assign shamt = slot_ir[RB_HI:RB_LO];
	// Branch displacement is split around the Ra and Rb fields
	assign bdisp = {slot_ir[35:29], slot_ir[12:8]};
	assign jdisp = slot_ir[35:10];
	assign ldisp = slot_ir[31:22];
	// Store displacement uses the Rt field for its low bits
	assign sdisp = {slot_ir[35:32], slot_ir[13:8]};

	always_comb begin
		case (imm_kind)
		IMM_SEXT14:
			imm = {{(XLEN-IMM14_W){imm14[IMM14_W-1]}}, imm14};
		IMM_ONES14:
			imm = {{(XLEN-IMM14_W){1'b1}}, imm14};
		IMM_ZEXT14:
			imm = {{(XLEN-IMM14_W){1'b0}}, imm14};
		IMM_SHAMT:
			imm = {{(XLEN-REG_W){1'b0}}, shamt};
		IMM_BRANCH:
			imm = {{(XLEN-12){bdisp[11]}}, bdisp};
		IMM_JUMP:
			imm = {{(XLEN-26){jdisp[25]}}, jdisp};
		IMM_LOAD:
			imm = {{(XLEN-10){ldisp[9]}}, ldisp};
		IMM_STORE:
			imm = {{(XLEN-10){sdisp[9]}}, sdisp};
		default:
			imm = '0;
		endcase
	end

endmodule

// File: hdl/any1_isa_pkg.sv
/* Any1 scalar instruction set */

package any1_isa_pkg;

	// Default width of an instruction word
	localparam int INSN_WIDTH = 36;

	// Width of a register specifier
	localparam int REG_W = 6;

	// ==========================================================
	// Field positions within the instruction word
	// ==========================================================
	localparam int OPC_HI = 7;
	localparam int OPC_LO = 0;
	localparam int RT_HI = 13;
	localparam int RT_LO = 8;
	localparam int RA_HI = 21;
	localparam int RA_LO = 16;
	localparam int RB_HI = 27;
	localparam int RB_LO = 22;
	localparam int FUNC_HI = 35;
	localparam int FUNC_LO = 30;
	localparam int IMM14_HI = 35;
	localparam int IMM14_LO = 22;

	// ==========================================================
	// Major opcodes kept by the scalar decoder
	// ==========================================================
	typedef enum logic [7:0] {
		BRK   = 8'h00,
		R1    = 8'h01,
		R2    = 8'h02,
		R3    = 8'h03,
		ADDI  = 8'h04,
		MULI  = 8'h06,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SLTI  = 8'h0C,
		SLTUI = 8'h0D,
		DIVI  = 8'h0F,
		JAL   = 8'h42,
		// Conditional branches share the 0x48 block
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BGE   = 8'h4B,
		BLTU  = 8'h4C,
		BGEU  = 8'h4D,
		LDx   = 8'h60,
		STx   = 8'h70,
		NOP   = 8'hF1
	} opcode_e;

	// Function codes of the R1, R2 and R3 groups are kept distinct
	typedef enum logic [5:0] {
		ADD   = 6'h04,
		SUB   = 6'h05,
		AND   = 6'h08,
		OR    = 6'h09,
		XOR   = 6'h0A,
		MUL   = 6'h10,
		MULU  = 6'h11,
		DIV   = 6'h18,
		DIVU  = 6'h19,
		SLL   = 6'h20,
		SRL   = 6'h21,
		SLLI  = 6'h28,
		SRLI  = 6'h29,
		SEQ   = 6'h30,
		SLT   = 6'h32,
		SLTU  = 6'h34,
		ABS   = 6'h38,
		NABS  = 6'h39,
		NOT   = 6'h3A,
		CTLZ  = 6'h3B,
		CTPOP = 6'h3C,
		CHK   = 6'h3F
	} func_e;

endpackage

// File: hdl/any1_opcode_classify.sv
/* Opcode and function classification */

`timescale 1ns/1ns

module any1_opcode_classify import any1_isa_pkg::*, any1_uop_pkg::*; #(
	parameter int INSN_W = INSN_WIDTH,
	parameter int XLEN = 64
) (
	input  logic [INSN_W-1:0] slot_ir,
	output logic              ui,
	output logic              rfwr,
	output logic              need_rb,
	output logic              need_rc,
	output logic              rc_en,
	output logic              mc,
	output logic              branch,
	output logic              mem_op,
	output imm_kind_e         imm_kind,
	output rt_sel_e           rt_sel
);

	opcode_e opc;
	func_e   fn;

	assign opc = opcode_e'(slot_ir[OPC_HI:OPC_LO]);
	assign fn = func_e'(slot_ir[FUNC_HI:FUNC_LO]);

	always_comb begin
		ui = 1'b1;
		rfwr = 1'b0;
		need_rb = 1'b0;
		need_rc = 1'b0;
		rc_en = 1'b0;
		mc = 1'b0;
		branch = 1'b0;
		mem_op = 1'b0;
		imm_kind = IMM_NONE;
		rt_sel = RT_NONE;
		case (opc)
		BRK, NOP:
			ui = 1'b0;
		// ==========================================================
		// Register forms
		// ==========================================================
		R1:
			if (fn inside {ABS, NABS, NOT, CTLZ, CTPOP}) begin
				ui = 1'b0;
				rfwr = 1'b1;
				rt_sel = RT_FIELD;
			end
		R2: begin
			// Rb is wanted even when the function is unknown
			need_rb = 1'b1;
			case (fn)
			ADD, SUB, AND, OR, XOR, SLL, SRL, SEQ, SLT, SLTU: begin
				ui = 1'b0;
				rfwr = 1'b1;
				rt_sel = RT_FIELD;
			end
			MUL, MULU, DIV, DIVU: begin
				ui = 1'b0;
				rfwr = 1'b1;
				mc = 1'b1;
				rt_sel = RT_FIELD;
			end
			SLLI, SRLI: begin
				ui = 1'b0;
				rfwr = 1'b1;
				rt_sel = RT_FIELD;
				imm_kind = IMM_SHAMT;
			end
			default: ;
			endcase
		end
		R3: begin
			need_rb = 1'b1;
			if (fn == CHK) begin
				ui = 1'b0;
				need_rc = 1'b1;
				rc_en = 1'b1;
			end
		end
		// ==========================================================
		// Immediate, control transfer and memory forms
		// ==========================================================
		ADDI, SLTI, MULI, DIVI, ANDI, ORI, XORI, SLTUI: begin
			ui = 1'b0;
			rfwr = 1'b1;
			rt_sel = RT_FIELD;
			mc = (opc == MULI) || (opc == DIVI);
			if (opc == ANDI)
				imm_kind = IMM_ONES14;
			else if (opc inside {ORI, XORI, SLTUI})
				imm_kind = IMM_ZEXT14;
			else
				imm_kind = IMM_SEXT14;
		end
		BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
			ui = 1'b0;
			branch = 1'b1;
			need_rb = 1'b1;
			imm_kind = IMM_BRANCH;
		end
		JAL: begin
			ui = 1'b0;
			rfwr = 1'b1;
			rt_sel = RT_LINK;
			imm_kind = IMM_JUMP;
		end
		LDx: begin
			ui = 1'b0;
			rfwr = 1'b1;
			rt_sel = RT_FIELD;
			mc = 1'b1;
			mem_op = 1'b1;
			imm_kind = IMM_LOAD;
		end
		STx: begin
			ui = 1'b0;
			need_rb = 1'b1;
			mc = 1'b1;
			mem_op = 1'b1;
			imm_kind = IMM_STORE;
		end
		default: ;
		endcase
	end

endmodule

// File: hdl/any1_uop_pkg.sv
/* Decoded operation types */

package any1_uop_pkg;

	// ==========================================================
	// Immediate extension rules
	// ==========================================================
	typedef enum logic [3:0] {
		IMM_NONE   = 4'd0,
		// 14-bit immediate with sign, ones or zeros above it
		IMM_SEXT14 = 4'd1,
		IMM_ONES14 = 4'd2,
		IMM_ZEXT14 = 4'd3,
		// Shift count taken from the Rb field
		IMM_SHAMT  = 4'd4,
		IMM_BRANCH = 4'd5,
		IMM_JUMP   = 4'd6,
		// Ten-bit displacements of loads and stores
		IMM_LOAD   = 4'd7,
		IMM_STORE  = 4'd8
	} imm_kind_e;

	// ==========================================================
	// Target register selection
	// ==========================================================
	typedef enum logic [1:0] {
		RT_NONE  = 2'd0,
		RT_FIELD = 2'd1,
		// Link register number for JAL
		RT_LINK  = 2'd2
	} rt_sel_e;

endpackage

// File: project.f
+incdir+include
hdl/any1_isa_pkg.sv
hdl/any1_uop_pkg.sv
hdl/any1_fetch_port.sv
hdl/any1_opcode_classify.sv
hdl/any1_imm_gen.sv
hdl/any1_decode_buffer.sv
hdl/any1_decode_top.sv
verif/any1_decode_tb.sv

// File: include/any1_decode_ref.svh
/* Reference scalar decode */

`ifndef ANY1_DECODE_REF_SVH
`define ANY1_DECODE_REF_SVH

// Flag order is {ui, rfwr, need_rb, need_rc, mc, branch, mem_op}
function automatic void any1_decode_ref(
	input  logic [INSN_WIDTH-1:0] ir,
	output logic [6:0]            flags,
	output logic [REG_W-1:0]      ra,
	output logic [REG_W-1:0]      rb,
	output logic [REG_W-1:0]      rc,
	output logic [REG_W-1:0]      rt,
	output logic [63:0]           imm
);
	opcode_e opc;
	func_e   fn;

	opc = opcode_e'(ir[OPC_HI:OPC_LO]);
	fn = func_e'(ir[FUNC_HI:FUNC_LO]);
	ra = ir[RA_HI:RA_LO];
	rb = ir[RB_HI:RB_LO];
	rc = '0;
	rt = '0;
	imm = '0;
	flags = 7'b1000000;
	case (opc)
	BRK, NOP:
		flags = 7'b0000000;
	R1:
		if (fn inside {ABS, NABS, NOT, CTLZ, CTPOP}) begin
			flags = 7'b0100000;
			rt = ir[RT_HI:RT_LO];
		end
	R2: begin
		flags = 7'b1010000;
		if (fn inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SEQ, SLT, SLTU,
				MUL, MULU, DIV, DIVU, SLLI, SRLI}) begin
			flags = 7'b0110000;
			rt = ir[RT_HI:RT_LO];
		end
		if (fn inside {MUL, MULU, DIV, DIVU})
			flags[2] = 1'b1;
		if (fn inside {SLLI, SRLI})
			imm = {58'd0, ir[RB_HI:RB_LO]};
	end
	R3: begin
		flags = 7'b1010000;
		if (fn == CHK) begin
			flags = 7'b0011000;
			rc = ir[RT_HI:RT_LO];
		end
	end
	ADDI, SLTI, MULI, DIVI, ANDI, ORI, XORI, SLTUI: begin
		flags = (opc inside {MULI, DIVI}) ? 7'b0100100 : 7'b0100000;
		rt = ir[RT_HI:RT_LO];
		if (opc == ANDI)
			imm = {{50{1'b1}}, ir[35:22]};
		else if (opc inside {ORI, XORI, SLTUI})
			imm = {50'd0, ir[35:22]};
		else
			imm = {{50{ir[35]}}, ir[35:22]};
	end
	BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
		flags = 7'b0010010;
		imm = {{52{ir[35]}}, ir[35:29], ir[12:8]};
	end
	JAL: begin
		flags = 7'b0100000;
		rt = {4'd0, ir[9:8]};
		imm = {{38{ir[35]}}, ir[35:10]};
	end
	LDx: begin
		flags = 7'b0100101;
		rt = ir[RT_HI:RT_LO];
		imm = {{54{ir[31]}}, ir[31:22]};
	end
	STx: begin
		flags = 7'b0010101;
		imm = {{54{ir[35]}}, ir[35:32], ir[13:8]};
	end
	default: ;
	endcase
endfunction

`endif

// File: verif/any1_decode_tb.sv
/* Decode stage testbench */

`timescale 1ns/1ns

module any1_decode_tb import any1_isa_pkg::*, any1_uop_pkg::*; ();

	`include "any1_decode_ref.svh"

	localparam int WAIT_LIMIT = 20;
	// Cycles that in_ack must stay low while the slot and buffer are full
	localparam int HOLD_CYCLES = 6;

	logic                  clk;
	logic                  rst_n;
	logic                  in_req;
	logic [INSN_WIDTH-1:0] in_ir;
	logic [63:0]           in_ip;
	logic                  in_ack;
	logic                  out_ack;
	logic                  out_req;
	logic [63:0]           out_ip;
	logic [REG_W-1:0]      out_ra;
	logic [REG_W-1:0]      out_rb;
	logic [REG_W-1:0]      out_rc;
	logic [REG_W-1:0]      out_rt;
	logic                  out_rfwr;
	logic                  out_need_rb;
	logic                  out_need_rc;
	logic                  out_mc;
	logic                  out_branch;
	logic                  out_mem_op;
	logic                  out_ui;
	logic [63:0]           out_imm;

	logic [31:0] lcg_state = 32'd74;
	string       cur_name;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;
	logic        aborted;

	func_e      r1_funcs [5] = '{ABS, NABS, NOT, CTLZ, CTPOP};
	func_e      r2_funcs [16] = '{ADD, SUB, AND, OR, XOR, MUL, MULU, DIV, DIVU,
		SLL, SRL, SLLI, SRLI, SEQ, SLT, SLTU};
	opcode_e    imm_opcs [8] = '{ADDI, ANDI, ORI, XORI, MULI, DIVI, SLTI, SLTUI};
	opcode_e    branch_opcs [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
	logic [7:0] bad_opcs [5] = '{8'h05, 8'h07, 8'h20, 8'h50, 8'hFF};
	logic [5:0] bad_funcs [3] = '{6'h00, 6'h15, 6'h3E};

	any1_decode_top #(.INSN_W(INSN_WIDTH), .XLEN(64)) dut0 (
		.clk(clk), .rst_n(rst_n),
		.in_req(in_req), .in_ir(in_ir), .in_ip(in_ip), .in_ack(in_ack),
		.out_ack(out_ack), .out_req(out_req), .out_ip(out_ip),
		.out_ra(out_ra), .out_rb(out_rb), .out_rc(out_rc), .out_rt(out_rt),
		.out_rfwr(out_rfwr), .out_need_rb(out_need_rb), .out_need_rc(out_need_rc),
		.out_mc(out_mc), .out_branch(out_branch), .out_mem_op(out_mem_op),
		.out_ui(out_ui), .out_imm(out_imm)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Random instruction word with the opcode field forced
	function logic [INSN_WIDTH-1:0] with_opcode(input logic [7:0] opc);
		logic [31:0]           hi;
		logic [INSN_WIDTH-1:0] ir;
		hi = lcg_next();
		ir = {hi[3:0], lcg_next()};
		ir[OPC_HI:OPC_LO] = opc;
		return ir;
	endfunction

	// ==========================================================
	// Bookkeeping and handshake helpers
	// ==========================================================
	task automatic report_mismatch(input string field, input logic [63:0] exp,
			input logic [63:0] act);
		$display("mismatch %s %s expected %h actual %h", cur_name, field, exp, act);
		test_errors++;
	endtask

	task automatic start_test(input string name);
		cur_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0 || aborted) begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", cur_name, test_errors);
		end else
			$display("test %s: ok", cur_name);
	endtask

	task automatic wait_in_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (!aborted && in_ack !== level && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!aborted && in_ack !== level) begin
			$display("timeout in %s: in_ack never went to %0d while %s", cur_name, level, what);
			aborted = 1'b1;
		end
	endtask

	task automatic wait_out_req(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (!aborted && out_req !== level && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!aborted && out_req !== level) begin
			$display("timeout in %s: out_req never went to %0d while %s", cur_name, level, what);
			aborted = 1'b1;
		end
	endtask

	task automatic send_insn(input logic [INSN_WIDTH-1:0] ir, input logic [63:0] ip);
		wait_in_ack(1'b0, "waiting to send");
		@(negedge clk);
		in_req = 1'b1;
		in_ir = ir;
		in_ip = ip;
		wait_in_ack(1'b1, "sending");
		in_req = 1'b0;
		wait_in_ack(1'b0, "closing the fetch handshake");
	endtask

	// Takes one result from issue and compares it with the reference decode
	task automatic receive_check(input logic [INSN_WIDTH-1:0] ir, input logic [63:0] ip);
		logic [6:0]       exp_flags;
		logic [6:0]       got_flags;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] rc;
		logic [REG_W-1:0] rt;
		logic [63:0]      imm;
		wait_out_req(1'b1, "waiting for a result");
		if (aborted)
			return;
		any1_decode_ref(ir, exp_flags, ra, rb, rc, rt, imm);
		got_flags = {out_ui, out_rfwr, out_need_rb, out_need_rc, out_mc, out_branch,
			out_mem_op};
		assert (got_flags === exp_flags) else report_mismatch("flags", 64'(exp_flags),
			64'(got_flags));
		assert (out_ra === ra) else report_mismatch("ra", 64'(ra), 64'(out_ra));
		assert (out_rb === rb) else report_mismatch("rb", 64'(rb), 64'(out_rb));
		assert (out_rc === rc) else report_mismatch("rc", 64'(rc), 64'(out_rc));
		assert (out_rt === rt) else report_mismatch("rt", 64'(rt), 64'(out_rt));
		assert (out_imm === imm) else report_mismatch("imm", imm, out_imm);
		assert (out_ip === ip) else report_mismatch("ip", ip, out_ip);
		out_ack = 1'b1;
		wait_out_req(1'b0, "closing the issue handshake");
		out_ack = 1'b0;
	endtask

	task automatic run_insn(input logic [INSN_WIDTH-1:0] ir);
		logic [63:0] ip;
		if (aborted)
			return;
		ip = {lcg_next(), lcg_next()};
		send_insn(ir, ip);
		receive_check(ir, ip);
	endtask

	// Three instructions against a stalled issue side
	task automatic back_pressure();
		logic [INSN_WIDTH-1:0] irs [3];
		logic [63:0]           ips [3];
		for (int i = 0; i < 3; i++) begin
			irs[i] = with_opcode(ADDI);
			ips[i] = {lcg_next(), lcg_next()};
		end
		send_insn(irs[0], ips[0]);
		send_insn(irs[1], ips[1]);
		if (aborted)
			return;
		@(negedge clk);
		in_req = 1'b1;
		in_ir = irs[2];
		in_ip = ips[2];
		for (int i = 0; i < HOLD_CYCLES; i++) begin
			@(negedge clk);
			assert (in_ack === 1'b0) else report_mismatch("in_ack", 64'd0, 64'(in_ack));
		end
		receive_check(irs[0], ips[0]);
		wait_in_ack(1'b1, "sending after the stall");
		in_req = 1'b0;
		wait_in_ack(1'b0, "closing the fetch handshake");
		receive_check(irs[1], ips[1]);
		receive_check(irs[2], ips[2]);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial begin
		logic [INSN_WIDTH-1:0] ir;
		rst_n = 1'b0;
		in_req = 1'b0;
		in_ir = '0;
		in_ip = '0;
		out_ack = 1'b0;
		aborted = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		total_errors = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		start_test("reset");
		assert (in_ack === 1'b0) else report_mismatch("in_ack", 64'd0, 64'(in_ack));
		assert (out_req === 1'b0) else report_mismatch("out_req", 64'd0, 64'(out_req));
		finish_test();

		start_test("register_forms");
		for (int i = 0; i < 5; i++) begin
			ir = with_opcode(R1);
			ir[FUNC_HI:FUNC_LO] = r1_funcs[i];
			run_insn(ir);
		end
		for (int i = 0; i < 16; i++) begin
			ir = with_opcode(R2);
			ir[FUNC_HI:FUNC_LO] = r2_funcs[i];
			run_insn(ir);
		end
		ir = with_opcode(R3);
		ir[FUNC_HI:FUNC_LO] = CHK;
		run_insn(ir);
		finish_test();

		start_test("immediate_alu");
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 2; k++) begin
				ir = with_opcode(imm_opcs[i]);
				ir[35] = k[0];
				run_insn(ir);
			end
		end
		for (int k = 0; k < 4; k++) begin
			ir = with_opcode(R2);
			ir[FUNC_HI:FUNC_LO] = k[0] ? SRLI : SLLI;
			run_insn(ir);
		end
		finish_test();

		start_test("control_transfer");
		for (int i = 0; i < 6; i++) begin
			for (int k = 0; k < 2; k++) begin
				ir = with_opcode(branch_opcs[i]);
				ir[35] = k[0];
				run_insn(ir);
			end
		end
		for (int k = 0; k < 4; k++) begin
			ir = with_opcode(JAL);
			ir[35] = k[0];
			run_insn(ir);
		end
		finish_test();

		start_test("memory");
		for (int k = 0; k < 6; k++) begin
			ir = with_opcode(LDx);
			ir[31] = k[0];
			run_insn(ir);
			ir = with_opcode(STx);
			ir[35] = k[0];
			run_insn(ir);
		end
		finish_test();

		start_test("unimplemented");
		for (int i = 0; i < 5; i++)
			run_insn(with_opcode(bad_opcs[i]));
		for (int i = 0; i < 3; i++) begin
			ir = with_opcode(R2);
			ir[FUNC_HI:FUNC_LO] = bad_funcs[i];
			run_insn(ir);
		end
		run_insn(with_opcode(BRK));
		run_insn(with_opcode(NOP));
		finish_test();

		start_test("back_pressure");
		back_pressure();
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
		if (tests_failed == 0 && !aborted)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
